/* verilog/tile_defines.svh */
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Core ports per tile, same count for slave and master ports
`define TILE_NUM_PORTS 2

// SRAM banks per tile
`define TILE_NUM_BANKS 4

// Tiles in the cluster
`define TILE_NUM_TILES 4

// Words in one bank
`define TILE_BANK_WORDS 64

`define TILE_DATA_WIDTH 32

// Outstanding reads per core
`define TILE_MAX_READS 2

`endif

/* verilog/tile_map_pkg.sv */
`include "tile_defines.svh"
`default_nettype none

package tile_map_pkg;

  typedef logic [$clog2(`TILE_NUM_TILES)-1:0] tile_id_t;
  typedef logic [$clog2(`TILE_NUM_BANKS)-1:0] bank_sel_t;

  // Word index inside one bank
  typedef logic [$clog2(`TILE_BANK_WORDS)-1:0] bank_addr_t;

  // Address inside a tile, tile field already removed
  typedef struct packed {
    bank_addr_t word;
    bank_sel_t  bank;
  } tile_addr_t;

  // Crossbar initiators: core ports first, then slave ports
  typedef logic [$clog2(2 * `TILE_NUM_PORTS)-1:0] xbar_ini_t;

  typedef enum logic {
    ROUTE_LOCAL,
    ROUTE_REMOTE
  } route_t;

endpackage

`default_nettype wire

/* verilog/tcdm_pkg.sv */
`include "tile_defines.svh"
`default_nettype none

package tcdm_pkg;

  typedef logic [31:0]                    addr_t;
  typedef logic [`TILE_DATA_WIDTH-1:0]    data_t;
  typedef logic [`TILE_DATA_WIDTH/8-1:0]  strb_t;

  // Global core index, tile then port
  typedef logic [$clog2(`TILE_NUM_TILES * `TILE_NUM_PORTS)-1:0] core_id_t;

  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t data;
    strb_t strb;
  } tcdm_req_t;

  typedef struct packed {
    data_t data;
  } tcdm_resp_t;

  typedef struct packed {
    tile_map_pkg::tile_addr_t addr;
    logic                     we;
    data_t                    data;
    strb_t                    strb;
    core_id_t                 core_id;
  } tcdm_slave_req_t;

  typedef struct packed {
    data_t    data;
    core_id_t core_id;
  } tcdm_slave_resp_t;

  // Bank side, tagged with the initiator for the way back
  typedef struct packed {
    tile_map_pkg::bank_addr_t addr;
    logic                     we;
    data_t                    data;
    strb_t                    strb;
    tile_map_pkg::xbar_ini_t  ini;
    core_id_t                 core_id;
  } bank_req_t;

  typedef struct packed {
    data_t                   data;
    tile_map_pkg::xbar_ini_t ini;
    core_id_t                core_id;
  } bank_resp_t;

endpackage

`default_nettype wire

/* verilog/tcdm_pipe_reg.sv */
`default_nettype none

module tcdm_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  payload_t data_q;
  logic     valid_q;

  // Room when empty or when the entry leaves this cycle
  assign ready_o = ~valid_q | ready_i;
  assign data_o  = data_q;
  assign valid_o = valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/tcdm_bank.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  tcdm_pkg::bank_req_t  req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output tcdm_pkg::bank_resp_t resp_o,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i
);
  import tcdm_pkg::*;

  data_t      mem_q [`TILE_BANK_WORDS];
  data_t      bit_mask;
  bank_resp_t resp_q;
  logic       resp_valid_q;
  logic       req_fire;

  // Byte enables to bit mask
  for (genvar i = 0; i < `TILE_DATA_WIDTH / 8; i++) begin : gen_bit_mask
    assign bit_mask[8*i +: 8] = {8{req_i.strb[i]}};
  end

  // New request allowed in the cycle the old response is taken
  assign req_ready_o  = ~resp_valid_q | resp_ready_i;
  assign req_fire     = req_valid_i & req_ready_o;
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.we) begin
        mem_q[req_i.addr] <= (mem_q[req_i.addr] & ~bit_mask) | (req_i.data & bit_mask);
      end else begin
        resp_q.data    <= mem_q[req_i.addr];
        resp_q.ini     <= req_i.ini;
        resp_q.core_id <= req_i.core_id;
      end
    end
  end

  // Writes never raise a response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      resp_valid_q <= req_valid_i & ~req_i.we;
    end
  end

endmodule

`default_nettype wire

/* verilog/tcdm_local_xbar.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_local_xbar (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  tcdm_pkg::bank_req_t     [2*`TILE_NUM_PORTS-1:0] ini_req_i,
  input  tile_map_pkg::bank_sel_t [2*`TILE_NUM_PORTS-1:0] ini_bank_i,
  input  logic                    [2*`TILE_NUM_PORTS-1:0] ini_valid_i,
  output logic                    [2*`TILE_NUM_PORTS-1:0] ini_ready_o,
  output tcdm_pkg::bank_resp_t    [2*`TILE_NUM_PORTS-1:0] ini_resp_o,
  output logic                    [2*`TILE_NUM_PORTS-1:0] ini_resp_valid_o,
  input  logic                    [2*`TILE_NUM_PORTS-1:0] ini_resp_ready_i,
  output tcdm_pkg::bank_req_t     [`TILE_NUM_BANKS-1:0]   bank_req_o,
  output logic                    [`TILE_NUM_BANKS-1:0]   bank_valid_o,
  input  logic                    [`TILE_NUM_BANKS-1:0]   bank_ready_i,
  input  tcdm_pkg::bank_resp_t    [`TILE_NUM_BANKS-1:0]   bank_resp_i,
  input  logic                    [`TILE_NUM_BANKS-1:0]   bank_resp_valid_i,
  output logic                    [`TILE_NUM_BANKS-1:0]   bank_resp_ready_o
);
  import tcdm_pkg::*;
  import tile_map_pkg::*;

  localparam int unsigned NumIni   = 2 * `TILE_NUM_PORTS;
  localparam int unsigned NumBanks = `TILE_NUM_BANKS;

  xbar_ini_t [NumBanks-1:0] rr_q;
  xbar_ini_t [NumBanks-1:0] win_idx;
  logic      [NumBanks-1:0] win_valid;
  logic      [NumIni-1:0]   resp_stall;
  logic      [NumIni-1:0]   req_active;

  // An initiator with a stuck response waits, so two banks never race its replies
  assign resp_stall = ini_resp_valid_o & ~ini_resp_ready_i;
  assign req_active = ini_valid_i & ~resp_stall;

  // Round-robin pick per bank, search starts at the pointer
  always_comb begin
    xbar_ini_t idx;
    idx = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      win_valid[b] = 1'b0;
      win_idx[b]   = '0;
      for (int unsigned k = 0; k < NumIni; k++) begin
        idx = rr_q[b] + xbar_ini_t'(k);
        if (!win_valid[b] && req_active[idx] && ini_bank_i[idx] == bank_sel_t'(b)) begin
          win_valid[b] = 1'b1;
          win_idx[b]   = idx;
        end
      end
    end
  end

  // Forward the winner and stamp its index
  always_comb begin
    ini_ready_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_req_o[b]     = ini_req_i[win_idx[b]];
      bank_req_o[b].ini = win_idx[b];
      if (win_valid[b] && bank_ready_i[b]) begin
        ini_ready_o[win_idx[b]] = 1'b1;
      end
    end
  end

  assign bank_valid_o = win_valid;

  // Pointer moves past the last granted initiator
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (win_valid[b] && bank_ready_i[b]) begin
          rr_q[b] <= win_idx[b] + 1'b1;
        end
      end
    end
  end

  // Responses steered back by the stamped index
  always_comb begin
    ini_resp_o       = '0;
    ini_resp_valid_o = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_resp_ready_o[b] = ini_resp_ready_i[bank_resp_i[b].ini];
      if (bank_resp_valid_i[b]) begin
        ini_resp_o[bank_resp_i[b].ini]       = bank_resp_i[b];
        ini_resp_valid_o[bank_resp_i[b].ini] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/tcdm_core_demux.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_core_demux #(
  parameter int unsigned PortIdx = 0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  tile_map_pkg::tile_id_t  tile_id_i,
  input  tcdm_pkg::tcdm_req_t     core_req_i,
  input  logic                    core_valid_i,
  output logic                    core_ready_o,
  output tcdm_pkg::tcdm_resp_t    core_resp_o,
  output logic                    core_resp_valid_o,
  output tcdm_pkg::bank_req_t     local_req_o,
  output tile_map_pkg::bank_sel_t local_bank_o,
  output logic                    local_valid_o,
  input  logic                    local_ready_i,
  input  tcdm_pkg::bank_resp_t    local_resp_i,
  input  logic                    local_resp_valid_i,
  output tcdm_pkg::tcdm_req_t     mst_req_o,
  output logic                    mst_valid_o,
  input  logic                    mst_ready_i,
  input  tcdm_pkg::tcdm_resp_t    mst_resp_i,
  input  logic                    mst_resp_valid_i
);
  import tcdm_pkg::*;
  import tile_map_pkg::*;

  localparam int unsigned ByteOffW = $clog2(`TILE_DATA_WIDTH / 8);
  localparam int unsigned BankW    = $bits(bank_sel_t);
  localparam int unsigned TileW    = $bits(tile_id_t);
  localparam int unsigned WordW    = $bits(bank_addr_t);
  localparam int unsigned PortW    = $clog2(`TILE_NUM_PORTS);
  localparam int unsigned TileLsb  = ByteOffW + BankW;
  localparam int unsigned WordLsb  = TileLsb + TileW;
  localparam int unsigned TopLsb   = WordLsb + WordW;
  localparam int unsigned CntW     = $clog2(`TILE_MAX_READS + 1);

  typedef logic [PortW-1:0] port_idx_t;
  localparam port_idx_t PortId = port_idx_t'(PortIdx);

  route_t          route;
  route_t          route_q;
  logic [CntW-1:0] cnt_q;
  logic            hold;
  logic            read_fire;
  addr_t           addr;

  assign addr = core_req_i.addr;

  // Local inside the TCDM window and on this tile
  assign route = (addr[31:TopLsb] == '0 && addr[TileLsb +: TileW] == tile_id_i) ?
                 ROUTE_LOCAL : ROUTE_REMOTE;

  // In-flight reads share one target, keeps responses in order
  assign hold = (cnt_q == CntW'(`TILE_MAX_READS)) || (cnt_q != '0 && route_q != route);

  assign local_valid_o = core_valid_i & ~hold & (route == ROUTE_LOCAL);
  assign mst_valid_o   = core_valid_i & ~hold & (route == ROUTE_REMOTE);
  assign core_ready_o  = ~hold & ((route == ROUTE_LOCAL) ? local_ready_i : mst_ready_i);
  assign read_fire     = core_valid_i & core_ready_o & ~core_req_i.we;

  // Tile field dropped on the bank side
  assign local_bank_o        = addr[ByteOffW +: BankW];
  assign local_req_o.addr    = addr[WordLsb +: WordW];
  assign local_req_o.we      = core_req_i.we;
  assign local_req_o.data    = core_req_i.data;
  assign local_req_o.strb    = core_req_i.strb;
  assign local_req_o.ini     = '0;
  assign local_req_o.core_id = core_id_t'({tile_id_i, PortId});

  // Bank and tile trade places, port index sits below the tile
  assign mst_req_o.addr = addr_t'({addr[WordLsb +: WordW], addr[ByteOffW +: BankW],
                                   addr[TileLsb +: TileW], PortId, addr[ByteOffW-1:0]});
  assign mst_req_o.we   = core_req_i.we;
  assign mst_req_o.data = core_req_i.data;
  assign mst_req_o.strb = core_req_i.strb;

  assign core_resp_valid_o = local_resp_valid_i | mst_resp_valid_i;
  assign core_resp_o.data  = local_resp_valid_i ? local_resp_i.data : mst_resp_i.data;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      route_q <= ROUTE_LOCAL;
    end else begin
      if (read_fire) begin
        route_q <= route;
      end
      cnt_q <= cnt_q + CntW'(read_fire) - CntW'(core_resp_valid_o);
    end
  end

endmodule

`default_nettype wire

/* verilog/tcdm_tile.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_tile (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  tile_map_pkg::tile_id_t                             tile_id_i,
  input  tcdm_pkg::tcdm_req_t        [`TILE_NUM_PORTS-1:0]   core_req_i,
  input  logic                       [`TILE_NUM_PORTS-1:0]   core_req_valid_i,
  output logic                       [`TILE_NUM_PORTS-1:0]   core_req_ready_o,
  output tcdm_pkg::tcdm_resp_t       [`TILE_NUM_PORTS-1:0]   core_resp_o,
  output logic                       [`TILE_NUM_PORTS-1:0]   core_resp_valid_o,
  output tcdm_pkg::tcdm_req_t        [`TILE_NUM_PORTS-1:0]   mst_req_o,
  output logic                       [`TILE_NUM_PORTS-1:0]   mst_req_valid_o,
  input  logic                       [`TILE_NUM_PORTS-1:0]   mst_req_ready_i,
  input  tcdm_pkg::tcdm_resp_t       [`TILE_NUM_PORTS-1:0]   mst_resp_i,
  input  logic                       [`TILE_NUM_PORTS-1:0]   mst_resp_valid_i,
  input  tcdm_pkg::tcdm_slave_req_t  [`TILE_NUM_PORTS-1:0]   slv_req_i,
  input  logic                       [`TILE_NUM_PORTS-1:0]   slv_req_valid_i,
  output logic                       [`TILE_NUM_PORTS-1:0]   slv_req_ready_o,
  output tcdm_pkg::tcdm_slave_resp_t [`TILE_NUM_PORTS-1:0]   slv_resp_o,
  output logic                       [`TILE_NUM_PORTS-1:0]   slv_resp_valid_o,
  input  logic                       [`TILE_NUM_PORTS-1:0]   slv_resp_ready_i
);
  import tcdm_pkg::*;
  import tile_map_pkg::*;

  localparam int unsigned NumPorts = `TILE_NUM_PORTS;
  localparam int unsigned NumIni   = 2 * NumPorts;
  localparam int unsigned NumBanks = `TILE_NUM_BANKS;

  // Crossbar initiators, core ports low and slave ports high
  bank_req_t        [NumIni-1:0]   ini_req;
  bank_sel_t        [NumIni-1:0]   ini_bank;
  logic             [NumIni-1:0]   ini_valid;
  logic             [NumIni-1:0]   ini_ready;
  bank_resp_t       [NumIni-1:0]   ini_resp;
  logic             [NumIni-1:0]   ini_resp_valid;
  logic             [NumIni-1:0]   ini_resp_ready;

  bank_req_t        [NumBanks-1:0] bank_req;
  logic             [NumBanks-1:0] bank_valid;
  logic             [NumBanks-1:0] bank_ready;
  bank_resp_t       [NumBanks-1:0] bank_resp;
  logic             [NumBanks-1:0] bank_resp_valid;
  logic             [NumBanks-1:0] bank_resp_ready;

  tcdm_slave_req_t  [NumPorts-1:0] slv_req_q;
  tcdm_slave_resp_t [NumPorts-1:0] slv_resp_d;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_core
    tcdm_core_demux #(
      .PortIdx (p)
    ) i_core_demux (
      .clk_i              (clk_i),
      .rst_ni             (rst_ni),
      .tile_id_i          (tile_id_i),
      .core_req_i         (core_req_i[p]),
      .core_valid_i       (core_req_valid_i[p]),
      .core_ready_o       (core_req_ready_o[p]),
      .core_resp_o        (core_resp_o[p]),
      .core_resp_valid_o  (core_resp_valid_o[p]),
      .local_req_o        (ini_req[p]),
      .local_bank_o       (ini_bank[p]),
      .local_valid_o      (ini_valid[p]),
      .local_ready_i      (ini_ready[p]),
      .local_resp_i       (ini_resp[p]),
      .local_resp_valid_i (ini_resp_valid[p]),
      .mst_req_o          (mst_req_o[p]),
      .mst_valid_o        (mst_req_valid_o[p]),
      .mst_ready_i        (mst_req_ready_i[p]),
      .mst_resp_i         (mst_resp_i[p]),
      .mst_resp_valid_i   (mst_resp_valid_i[p])
    );

    // Local cores always take their response
    assign ini_resp_ready[p] = 1'b1;
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_slave
    tcdm_pipe_reg #(
      .payload_t (tcdm_slave_req_t)
    ) i_req_cut (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .data_i  (slv_req_i[p]),
      .valid_i (slv_req_valid_i[p]),
      .ready_o (slv_req_ready_o[p]),
      .data_o  (slv_req_q[p]),
      .valid_o (ini_valid[NumPorts+p]),
      .ready_i (ini_ready[NumPorts+p])
    );

    assign ini_bank[NumPorts+p] = slv_req_q[p].addr.bank;
    assign ini_req[NumPorts+p]  = '{
      addr:    slv_req_q[p].addr.word,
      we:      slv_req_q[p].we,
      data:    slv_req_q[p].data,
      strb:    slv_req_q[p].strb,
      ini:     '0,
      core_id: slv_req_q[p].core_id
    };
    assign slv_resp_d[p] = '{
      data:    ini_resp[NumPorts+p].data,
      core_id: ini_resp[NumPorts+p].core_id
    };

    tcdm_pipe_reg #(
      .payload_t (tcdm_slave_resp_t)
    ) i_resp_cut (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .data_i  (slv_resp_d[p]),
      .valid_i (ini_resp_valid[NumPorts+p]),
      .ready_o (ini_resp_ready[NumPorts+p]),
      .data_o  (slv_resp_o[p]),
      .valid_o (slv_resp_valid_o[p]),
      .ready_i (slv_resp_ready_i[p])
    );
  end

  tcdm_local_xbar i_local_xbar (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ini_req_i         (ini_req),
    .ini_bank_i        (ini_bank),
    .ini_valid_i       (ini_valid),
    .ini_ready_o       (ini_ready),
    .ini_resp_o        (ini_resp),
    .ini_resp_valid_o  (ini_resp_valid),
    .ini_resp_ready_i  (ini_resp_ready),
    .bank_req_o        (bank_req),
    .bank_valid_o      (bank_valid),
    .bank_ready_i      (bank_ready),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready)
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    tcdm_bank i_bank (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .req_i        (bank_req[b]),
      .req_valid_i  (bank_valid[b]),
      .req_ready_o  (bank_ready[b]),
      .resp_o       (bank_resp[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_ready_i (bank_resp_ready[b])
    );
  end

endmodule

`default_nettype wire

/* verification/tile_clk_gen.sv */
`default_nettype none

module tile_clk_gen (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    // Reset held for four rising edges
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verification/tcdm_tile_assertions.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_tile_assertions (
  input logic                                             clk_i,
  input logic                                             rst_ni,
  input logic                       [`TILE_NUM_PORTS-1:0] core_resp_valid_o,
  input tcdm_pkg::tcdm_req_t        [`TILE_NUM_PORTS-1:0] mst_req_o,
  input logic                       [`TILE_NUM_PORTS-1:0] mst_req_valid_o,
  input logic                       [`TILE_NUM_PORTS-1:0] mst_req_ready_i,
  input tcdm_pkg::tcdm_slave_req_t  [`TILE_NUM_PORTS-1:0] slv_req_i,
  input logic                       [`TILE_NUM_PORTS-1:0] slv_req_valid_i,
  input logic                       [`TILE_NUM_PORTS-1:0] slv_req_ready_o,
  input tcdm_pkg::tcdm_slave_resp_t [`TILE_NUM_PORTS-1:0] slv_resp_o,
  input logic                       [`TILE_NUM_PORTS-1:0] slv_resp_valid_o,
  input logic                       [`TILE_NUM_PORTS-1:0] slv_resp_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import tcdm_pkg::*;

  for (genvar p = 0; p < `TILE_NUM_PORTS; p++) begin : gen_port
    // Held payloads stay put until the handshake completes
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (slv_resp_valid_o[p] && !slv_resp_ready_i[p]) |=>
      (slv_resp_valid_o[p] && $stable(slv_resp_o[p])))
      else $error("Slave response changed while stalled on port %0d", p);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (mst_req_valid_o[p] && !mst_req_ready_i[p]) |=>
      (mst_req_valid_o[p] && $stable(mst_req_o[p])))
      else $error("Master request changed while stalled on port %0d", p);

    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (slv_req_valid_i[p] && !slv_req_ready_o[p]) |=>
      (slv_req_valid_i[p] && $stable(slv_req_i[p])))
      else $error("Slave request changed while stalled on port %0d", p);
  end

  assert property (@(posedge clk_i)
    !rst_ni |-> (core_resp_valid_o == '0 && slv_resp_valid_o == '0))
    else $error("Response valid raised during reset");

  // Index arithmetic relies on power-of-two counts
  assert property (@(posedge clk_i)
    ((`TILE_NUM_PORTS & (`TILE_NUM_PORTS - 1)) == 0) &&
    ((`TILE_NUM_BANKS & (`TILE_NUM_BANKS - 1)) == 0))
    else $error("Port or bank count is not a power of two");

endmodule

bind tcdm_tile tcdm_tile_assertions i_tile_assertions (.*);

`default_nettype wire

/* verification/tcdm_tile_tb.sv */
`include "tile_defines.svh"
`default_nettype none

module tcdm_tile_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import tcdm_pkg::*;
  import tile_map_pkg::*;

  localparam int NumPorts = `TILE_NUM_PORTS;
  localparam int Timeout  = 200;
  localparam logic [1:0] TileId = 2'd1;

  logic clk_i;
  logic rst_ni;

  tcdm_req_t        [NumPorts-1:0] core_req_i;
  logic             [NumPorts-1:0] core_req_valid_i;
  logic             [NumPorts-1:0] core_req_ready_o;
  tcdm_resp_t       [NumPorts-1:0] core_resp_o;
  logic             [NumPorts-1:0] core_resp_valid_o;
  tcdm_req_t        [NumPorts-1:0] mst_req_o;
  logic             [NumPorts-1:0] mst_req_valid_o;
  logic             [NumPorts-1:0] mst_req_ready_i;
  tcdm_resp_t       [NumPorts-1:0] mst_resp_i;
  logic             [NumPorts-1:0] mst_resp_valid_i;
  tcdm_slave_req_t  [NumPorts-1:0] slv_req_i;
  logic             [NumPorts-1:0] slv_req_valid_i;
  logic             [NumPorts-1:0] slv_req_ready_o;
  tcdm_slave_resp_t [NumPorts-1:0] slv_resp_o;
  logic             [NumPorts-1:0] slv_resp_valid_o;
  logic             [NumPorts-1:0] slv_resp_ready_i;

  data_t            model_mem [256];
  tcdm_slave_resp_t exp_q [NumPorts][$];
  logic             bp_en;

  tile_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  tcdm_tile dut_i (
    .clk_i, .rst_ni, .tile_id_i (TileId),
    .core_req_i, .core_req_valid_i, .core_req_ready_o, .core_resp_o, .core_resp_valid_o,
    .mst_req_o, .mst_req_valid_o, .mst_req_ready_i, .mst_resp_i, .mst_resp_valid_i,
    .slv_req_i, .slv_req_valid_i, .slv_req_ready_o, .slv_resp_o, .slv_resp_valid_o,
    .slv_resp_ready_i
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_core_resp(input int p, input tcdm_resp_t got, input tcdm_resp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at %0t: core %0d response %h, expected %h",
                                  $time, p, got.data, exp.data));
    end
  endtask

  task automatic check_mst_req(input int p, input tcdm_req_t got, input tcdm_req_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at %0t: master %0d request %h, expected %h",
                                  $time, p, got, exp));
    end
  endtask

  task automatic check_slv_resp(input int p, input tcdm_slave_resp_t got,
                                input tcdm_slave_resp_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at %0t: slave %0d response %h/%0d, expected %h/%0d",
                                  $time, p, got.data, got.core_id, exp.data, exp.core_id));
    end
  endtask

  task automatic check_file_value(input data_t file_val, input data_t model_val);
    if (file_val !== model_val) begin
      stop_with_failure($sformatf("MISMATCH at %0t: cases file expects %h, model holds %h",
                                  $time, file_val, model_val));
    end
  endtask

  function automatic int unsigned model_idx(input addr_t a);
    return {a[11:6], a[3:2]};
  endfunction

  function automatic bit is_local(input addr_t a);
    return (a[31:12] == '0) && (a[5:4] == TileId);
  endfunction

  // Word, bank, tile, port, byte offset from the top down
  function automatic addr_t scramble_addr(input addr_t a, input int p);
    return addr_t'({a[11:6], a[3:2], a[5:4], p[0], a[1:0]});
  endfunction

  function automatic data_t merge_bytes(input data_t old_val, input data_t new_val,
                                        input strb_t strb);
    data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  task automatic core_access(input int p, input logic we, input addr_t address,
                             input data_t data, input strb_t strb, input data_t exp,
                             input bit strict);
    tcdm_req_t   req;
    tcdm_resp_t  resp_exp;
    int          cnt;
    bit          local_hit;
    int unsigned idx;
    req       = '{addr: address, we: we, data: data, strb: strb};
    local_hit = is_local(address);
    idx       = model_idx(address);
    @(posedge clk_i);
    core_req_i[p]       <= req;
    core_req_valid_i[p] <= 1'b1;
    if (!local_hit) begin
      // Master port stalls the first cycle
      @(negedge clk_i);
      if (core_req_ready_o[p]) begin
        stop_with_failure("Remote core request accepted while the master port stalled");
      end
      @(posedge clk_i);
      mst_req_ready_i[p] <= 1'b1;
    end
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) stop_with_failure("Timeout: core request was never accepted");
    end while (!core_req_ready_o[p]);
    if (!local_hit) begin
      if (!mst_req_valid_o[p]) stop_with_failure("Remote core request left mst_req_valid_o low");
      check_mst_req(p, mst_req_o[p], '{addr: scramble_addr(address, p), we: we, data: data,
                                       strb: strb});
    end else if (mst_req_valid_o[p]) begin
      stop_with_failure("Local core request raised mst_req_valid_o");
    end
    @(posedge clk_i);
    core_req_valid_i[p] <= 1'b0;
    mst_req_ready_i[p]  <= 1'b0;
    if (we) begin
      if (local_hit) model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
    end else if (local_hit) begin
      resp_exp.data = model_mem[idx];
      check_file_value(exp, resp_exp.data);
      cnt = 0;
      do begin
        @(negedge clk_i);
        cnt++;
        if (cnt > Timeout) stop_with_failure("Timeout: local core read got no response");
      end while (!core_resp_valid_o[p]);
      if (strict && cnt != 1) stop_with_failure("Local core read response was not 1 cycle late");
      check_core_resp(p, core_resp_o[p], resp_exp);
    end else begin
      // Answer the remote read with the value from the cases file
      mst_resp_i[p]       <= '{data: exp};
      mst_resp_valid_i[p] <= 1'b1;
      @(negedge clk_i);
      if (!core_resp_valid_o[p]) stop_with_failure("Core missed the master response");
      resp_exp.data = exp;
      check_core_resp(p, core_resp_o[p], resp_exp);
      @(posedge clk_i);
      mst_resp_valid_i[p] <= 1'b0;
    end
  endtask

  task automatic slave_access(input int p, input logic we, input addr_t address,
                              input data_t data, input strb_t strb, input data_t exp,
                              input bit strict);
    tcdm_slave_req_t req;
    int              cnt;
    int unsigned     idx;
    idx = model_idx(address);
    req = '{addr: tile_addr_t'({address[11:6], address[3:2]}), we: we, data: data,
            strb: strb, core_id: core_id_t'($urandom)};
    @(posedge clk_i);
    slv_req_i[p]       <= req;
    slv_req_valid_i[p] <= 1'b1;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) stop_with_failure("Timeout: slave request was never accepted");
    end while (!slv_req_ready_o[p]);
    @(posedge clk_i);
    slv_req_valid_i[p] <= 1'b0;
    if (we) begin
      model_mem[idx] = merge_bytes(model_mem[idx], data, strb);
      // Posted write needs both cuts and the bank before anyone reads it
      repeat (3) @(posedge clk_i);
    end else begin
      check_file_value(exp, model_mem[idx]);
      exp_q[p].push_back('{data: model_mem[idx], core_id: req.core_id});
      if (strict) begin
        cnt = 0;
        do begin
          @(negedge clk_i);
          cnt++;
          if (cnt > Timeout) stop_with_failure("Timeout: slave read got no response");
        end while (!slv_resp_valid_o[p]);
        if (cnt != 3) stop_with_failure("Slave read response was not 3 cycles late");
      end
    end
  endtask

  task automatic wait_slave_idle(input int p);
    int cnt;
    cnt = 0;
    while (exp_q[p].size() != 0) begin
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) stop_with_failure("Timeout: slave responses still outstanding");
    end
  endtask

  // Slave response checker, in order per port
  always @(negedge clk_i) begin
    for (int p = 0; p < NumPorts; p++) begin
      if (rst_ni && slv_resp_valid_o[p] && slv_resp_ready_i[p]) begin
        if (exp_q[p].size() == 0) stop_with_failure("Slave response with no read pending");
        check_slv_resp(p, slv_resp_o[p], exp_q[p].pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    slv_resp_ready_i <= bp_en ? NumPorts'($urandom) : '1;
  end

  initial begin
    int          fd;
    int          n;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [7:0]  kind;
    int          idx;
    addr_t       address;
    data_t       data;
    strb_t       strb;
    data_t       exp;
    void'($urandom(88911));
    core_req_i       = '0;
    core_req_valid_i = '0;
    mst_req_ready_i  = '0;
    mst_resp_i       = '0;
    mst_resp_valid_i = '0;
    slv_req_i        = '0;
    slv_req_valid_i  = '0;
    slv_resp_ready_i = '1;
    bp_en            = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) stop_with_failure("Timeout: reset was never released");
    end while (!rst_ni);
    fd = $fopen("verification/tile_cases.txt", "r");
    if (fd == 0) stop_with_failure("Could not open the cases file");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n <= 1 || line.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%c %c %d %h %h %h %h", op, kind, idx, address, data, strb, exp);
      if (n != 7) stop_with_failure($sformatf("Malformed line in cases file: %s", line));
      if (kind != "P") begin
        for (int p = 0; p < NumPorts; p++) wait_slave_idle(p);
        bp_en = 1'b0;
      end
      case (kind)
        "C": core_access(idx, op == "W", address, data, strb, exp, 1'b1);
        "S": begin
          slave_access(idx, op == "W", address, data, strb, exp, 1'b1);
          wait_slave_idle(idx);
        end
        "P": begin
          bp_en = 1'b1;
          slave_access(idx, op == "W", address, data, strb, exp, 1'b0);
        end
        "X": begin
          // Slave starts a cycle early, its request cut puts both on the bank together
          fork
            begin
              @(posedge clk_i);
              core_access(idx, op == "W", address, data, strb, exp, 1'b0);
            end
            slave_access(idx, op == "W", (op == "W") ? address + 32'h40 : address, ~data,
                         strb, exp, 1'b0);
          join
          wait_slave_idle(idx);
        end
        default: stop_with_failure($sformatf("Unknown port kind in cases file: %s", line));
      endcase
    end
    $fclose(fd);
    for (int p = 0; p < NumPorts; p++) wait_slave_idle(p);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tile_cases.txt */
# op(W/R) kind(C core, S slave, P slave with back-pressure, X core and slave on one bank)
# port index, address, data, byte enables, expected read value (hex)
W C 0 00000010 11223344 f 00000000
R C 0 00000010 00000000 f 11223344
W C 1 00000054 aabbccdd f 00000000
W C 1 00000054 00556600 6 00000000
R C 1 00000054 00000000 f aa5566dd
W C 0 00000028 cafef00d 3 00000000
R C 1 00000068 00000000 f 0badbeef
W S 0 00000018 01020304 f 00000000
R S 0 00000018 00000000 f 01020304
R S 1 00000010 00000000 f 11223344
R P 0 00000054 00000000 f aa5566dd
R P 1 00000018 00000000 f 01020304
R P 0 00000010 00000000 f 11223344
W X 0 00000014 77778888 f 00000000
R X 1 00000014 00000000 f 77778888
R C 0 00000054 00000000 f 88887777

/* flist.f */
+incdir+verilog
verilog/tile_map_pkg.sv
verilog/tcdm_pkg.sv
verilog/tcdm_pipe_reg.sv
verilog/tcdm_bank.sv
verilog/tcdm_local_xbar.sv
verilog/tcdm_core_demux.sv
verilog/tcdm_tile.sv
verification/tile_clk_gen.sv
verification/tcdm_tile_assertions.sv
verification/tcdm_tile_tb.sv

/* Bender.yml */
package:
  name: tcdm_tile

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/tile_map_pkg.sv
      - verilog/tcdm_pkg.sv
      - verilog/tcdm_pipe_reg.sv
      - verilog/tcdm_bank.sv
      - verilog/tcdm_local_xbar.sv
      - verilog/tcdm_core_demux.sv
      - verilog/tcdm_tile.sv
  - target: test
    files:
      - verification/tile_clk_gen.sv
      - verification/tcdm_tile_assertions.sv
      - verification/tcdm_tile_tb.sv
